//--- all.f
+incdir+rtl
rtl/mmio_pkg.sv
rtl/mio_link_if.sv
rtl/mem_io_router.sv
rtl/bus_port.sv
rtl/clint.sv
rtl/mmio_core.sv
test/mmio_props.sv
test/tb_mmio_core.sv

//--- Makefile
# Verilator build and run for the mmio_core testbench

VERILATOR ?= verilator
TOP       := tb_mmio_core
FILELIST  := all.f
VFLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) rtl/mmio_macros.svh
PASS_MSG  := Done: no errors

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the testbench printed its pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_mmio_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_macros.svh"

module tb_mmio_core;
   import mmio_pkg::*;

   localparam word_t IO_KEY = 32'h5A5A_C3C3;     // I/O model returns addr ^ key
   localparam int    TMO    = 100;               // Cycles per wait

   typedef struct packed {
      mio_rsp_t rsp;
      logic     chk_data;                        // Low where the data is not predictable
      logic     to_dc;
      logic     to_io;
   } exp_t;

   logic   clk_in = 1'b0;
   logic   rst_n, req, rd, wr, ack, ack_fault, time_irq, sw_irq;
   logic   dc_req, dc_rd, dc_wr, dc_ack, io_req, io_rd, io_wr, io_ack, io_ack_fault;
   word_t  addr, wr_data, rd_data, dc_rw_addr, dc_wr_data, dc_ack_data;
   word_t  io_addr, io_wr_data, io_rd_data, ack_data;
   size_t  size, dc_size;
   integer seed = 32'hd671;
   int     cyc = 0, n_acks = 0, dc_count = 0, io_count = 0;
   int     dc_base, io_base, ack_cyc, dc_dly, io_dly;
   word_t  cache_mem [16];                       // Backing store of the cache model
   word_t  ref_mem [16];                         // Expected cache contents
   logic        m_msip;
   logic [63:0] m_cmp;
   exp_t     exp_cur;
   mio_rsp_t got_rsp;
   dc_req_t  exp_dc, dc_seen;
   io_req_t  exp_io, io_seen;

   mmio_core uut (.*);

   always #4 clk_in = ~clk_in;                   // 8 ns period
   always @(posedge clk_in) cyc <= cyc + 1;

   // ------------------------------
   function automatic word_t fill_word(int i);
      return 32'hC0DE_0000 ^ (i * 32'h0001_0203);
   endfunction

   // Expected CPU response and which bus the access should use
   function automatic exp_t ref_model(mio_req_t r, logic msip_m, logic [63:0] cmp_m);
      exp_t  e;
      word_t ofs;
      e = '0;
      e.chk_data = 1'b1;
      ofs = r.addr - `MMIO_CLINT_BASE;
      if (r.addr >= `MMIO_CLINT_BASE) begin
         case (ofs)
            32'd0:          e.rsp.rd_data = {31'b0, msip_m};
            32'd8:          e.rsp.rd_data = cmp_m[31:0];
            32'd12:         e.rsp.rd_data = cmp_m[63:32];
            32'd16, 32'd20: e.chk_data = 1'b0;   // mtime moves on every cycle
            default:        e.rsp.fault = 1'b1;  // Undefined or misaligned offset
         endcase
         if (r.wr && !e.rsp.fault)
            e.chk_data = 1'b0;
      end else if (r.addr >= `MMIO_EXT_IO_LO) begin
         e.to_io = 1'b1;
         e.rsp   = '{rd_data: r.addr ^ IO_KEY, fault: r.addr[2]};
      end else begin
         e.to_dc = 1'b1;
         if (r.rd)
            e.rsp.rd_data = ref_mem[r.addr[5:2]];   // Last word written there
      end
      return e;
   endfunction

   task automatic stop_run();
      $display("Done: errors found");
      $fatal(1, "simulation stopped on first failure");
   endtask

   task automatic value_error(string what);
      $display("** Error at %0t ns: %s", $time, what);
      stop_run();
   endtask

   task automatic check_rsp(mio_rsp_t got, mio_rsp_t exp, logic chk_data, string what);
      if (got.fault !== exp.fault || (chk_data && got.rd_data !== exp.rd_data))
         value_error($sformatf("%s got %h/%b expected %h/%b", what, got.rd_data, got.fault,
                               exp.rd_data, exp.fault));
   endtask

   task automatic check_dc(dc_req_t got, dc_req_t exp);
      if (got !== exp)
         value_error($sformatf("cache request got %h expected %h", got, exp));
   endtask

   task automatic check_io(io_req_t got, io_req_t exp);
      if (got !== exp)
         value_error($sformatf("I/O request got %h expected %h", got, exp));
   endtask

   task automatic check_bit(logic got, logic exp, string what);
      if (got !== exp)
         value_error($sformatf("%s got %b expected %b", what, got, exp));
   endtask

   // ------------------------------
   // Responder models ack after 1 to 4 cycles
   always begin : cache_model
      @(negedge clk_in);
      if (dc_req) begin
         dc_seen = '{rw_addr: dc_rw_addr, rd: dc_rd, wr: dc_wr, wr_data: dc_wr_data,
                     size: dc_size};
         dc_dly = 1 + int'($unsigned($random(seed)) % 4);
         repeat (dc_dly - 1) @(negedge clk_in);
         if (dc_wr)
            cache_mem[dc_rw_addr[5:2]] = dc_wr_data;
         dc_ack_data = dc_rd ? cache_mem[dc_rw_addr[5:2]] : '0;
         dc_ack   = 1'b1;
         dc_count = dc_count + 1;
         @(negedge clk_in);
         dc_ack = 1'b0;
      end
   end

   always begin : io_model
      @(negedge clk_in);
      if (io_req) begin
         io_seen = '{addr: io_addr, rd: io_rd, wr: io_wr, wr_data: io_wr_data};
         io_dly  = 1 + int'($unsigned($random(seed)) % 4);
         repeat (io_dly - 1) @(negedge clk_in);
         io_rd_data   = io_addr ^ IO_KEY;
         io_ack_fault = io_addr[2];              // Bit 2 set means a bus fault
         io_ack       = 1'b1;
         io_count     = io_count + 1;
         @(negedge clk_in);
         io_ack = 1'b0;
      end
   end

   // Checks every CPU ack against the reference
   always @(negedge clk_in) begin : compare
      if (rst_n && ack) begin
         got_rsp = '{rd_data: rd_data, fault: ack_fault};
         check_bit(req, 1'b1, "ack without a request");
         check_rsp(got_rsp, exp_cur.rsp, exp_cur.chk_data, "CPU response");
         check_bit(dc_count - dc_base == int'(exp_cur.to_dc), 1'b1, "cache bus use");
         check_bit(io_count - io_base == int'(exp_cur.to_io), 1'b1, "I/O bus use");
         if (exp_cur.to_dc)
            check_dc(dc_seen, exp_dc);
         if (exp_cur.to_io)
            check_io(io_seen, exp_io);
         ack_cyc  = cyc;
         ack_data = rd_data;
         n_acks   = n_acks + 1;
      end
   end

   // ------------------------------
   task automatic run_xfer(word_t a, logic r_en, logic w_en, word_t d, size_t s);
      mio_req_t r;
      int       n0;
      int       i;
      r = '{addr: a, rd: r_en, wr: w_en, wr_data: d, size: s};
      @(negedge clk_in);
      exp_cur = ref_model(r, m_msip, m_cmp);
      exp_dc  = '{rw_addr: a, rd: r_en, wr: w_en, wr_data: d, size: s};
      exp_io  = '{addr: a, rd: r_en, wr: w_en, wr_data: d};
      dc_base = dc_count;
      io_base = io_count;
      n0      = n_acks;
      {addr, rd, wr, wr_data, size} = r;
      req = 1'b1;
      i = 0;
      while (n_acks == n0 && i < TMO) begin
         @(posedge clk_in);
         i++;
      end
      if (n_acks == n0) begin
         $display("Timeout: no ack within %0d cycles for address %h", TMO, a);
         stop_run();
      end
      @(negedge clk_in);
      req = 1'b0;
      // Track the state the reference depends on
      if (w_en && a < `MMIO_EXT_IO_LO)
         ref_mem[a[5:2]] = d;
      if (w_en && a == `MMIO_CLINT_BASE)
         m_msip = d[0];
      if (w_en && a == `MMIO_CLINT_BASE + 32'd8)
         m_cmp[31:0] = d;
      if (w_en && a == `MMIO_CLINT_BASE + 32'd12)
         m_cmp[63:32] = d;
   endtask

   initial begin : stimulus
      word_t    a, d, t1, t2;
      logic     w;
      size_t    sz;
      int       i, c1, c2;
      mio_rsp_t d_rsp, c_rsp;
      rst_n = 1'b0;
      req = 1'b0;
      addr = '0;
      rd = 1'b0;
      wr = 1'b0;
      wr_data = '0;
      size = '0;
      dc_ack = 1'b0;
      dc_ack_data = '0;
      io_ack = 1'b0;
      io_ack_fault = 1'b0;
      io_rd_data = '0;
      m_msip = 1'b0;
      m_cmp = '1;
      for (i = 0; i < 16; i++) begin
         cache_mem[i] = fill_word(i);
         ref_mem[i]   = fill_word(i);
      end
      repeat (4) @(posedge clk_in);
      @(negedge clk_in);
      rst_n = 1'b1;
      @(negedge clk_in);
      check_bit(ack, 1'b0, "ack after reset");
      check_bit(dc_req, 1'b0, "dc_req after reset");
      check_bit(io_req, 1'b0, "io_req after reset");
      check_bit(time_irq, 1'b0, "time_irq after reset");
      check_bit(sw_irq, 1'b0, "sw_irq after reset");

      // Random mix of cache reads and writes
      for (i = 0; i < 24; i++) begin
         a  = 32'h0000_1000 | (word_t'($unsigned($random(seed)) % 16) << 2);
         w  = $random(seed);
         d  = $random(seed);
         sz = size_t'(1 << ($unsigned($random(seed)) % 3));
         run_xfer(a, !w, w, d, sz);
      end

      // External I/O range including both ends
      for (i = 0; i < 12; i++) begin
         a = `MMIO_EXT_IO_LO | (word_t'($unsigned($random(seed)) % 1024) << 2);
         w = $random(seed);
         d = $random(seed);
         run_xfer(a, !w, w, d, 3'd4);
      end
      run_xfer(`MMIO_EXT_IO_LO, 1'b0, 1'b1, 32'h1234_5678, 3'd4);
      run_xfer(`MMIO_EXT_IO_HI - 32'd3, 1'b1, 1'b0, '0, 3'd4);

      // msip and reserved offsets
      run_xfer(`MMIO_CLINT_BASE, 1'b0, 1'b1, 32'd1, 3'd4);
      check_bit(sw_irq, 1'b1, "sw_irq after msip set");
      run_xfer(`MMIO_CLINT_BASE, 1'b1, 1'b0, '0, 3'd4);
      run_xfer(`MMIO_CLINT_BASE, 1'b0, 1'b1, 32'd0, 3'd4);
      check_bit(sw_irq, 1'b0, "sw_irq after msip clear");
      run_xfer(`MMIO_CLINT_BASE, 1'b1, 1'b0, '0, 3'd4);
      run_xfer(`MMIO_CLINT_BASE + 32'd4, 1'b1, 1'b0, '0, 3'd4);
      run_xfer(`MMIO_CLINT_BASE + 32'd1, 1'b0, 1'b1, 32'd1, 3'd4);
      check_bit(sw_irq, 1'b0, "sw_irq after reserved write");
      run_xfer(`MMIO_CLINT_BASE + 32'h40, 1'b1, 1'b0, '0, 3'd4);

      // ------------------------------
      // Timer rate then compare match
      run_xfer(`MMIO_CLINT_BASE + 32'd16, 1'b1, 1'b0, '0, 3'd4);
      t1 = ack_data;
      c1 = ack_cyc;
      repeat (3 + int'($unsigned($random(seed)) % 8)) @(negedge clk_in);
      run_xfer(`MMIO_CLINT_BASE + 32'd16, 1'b1, 1'b0, '0, 3'd4);
      t2 = ack_data;
      c2 = ack_cyc;
      d_rsp = '{rd_data: t2 - t1, fault: 1'b0};
      c_rsp = '{rd_data: word_t'(c2 - c1), fault: 1'b0};
      check_rsp(d_rsp, c_rsp, 1'b1, "mtime delta against ack cycles");
      run_xfer(`MMIO_CLINT_BASE + 32'd8, 1'b0, 1'b1, t2 + 32'd40, 3'd4);
      run_xfer(`MMIO_CLINT_BASE + 32'd12, 1'b0, 1'b1, 32'd0, 3'd4);
      i = 0;
      while (i < TMO) begin
         // Irq is registered, so it reflects last cycle's mtime
         check_bit(time_irq, (t2 + word_t'(cyc - 1 - c2)) >= m_cmp[31:0], "time_irq");
         if (time_irq)
            break;
         @(negedge clk_in);
         i++;
      end
      if (!time_irq) begin
         $display("Timeout: time_irq never rose after mtimecmp was written");
         stop_run();
      end
      run_xfer(`MMIO_CLINT_BASE + 32'd8, 1'b1, 1'b0, '0, 3'd4);
      run_xfer(`MMIO_CLINT_BASE + 32'd12, 1'b0, 1'b1, 32'hFFFF_FFFF, 3'd4);
      i = 0;
      while (time_irq && i < TMO) begin
         @(negedge clk_in);
         i++;
      end
      if (time_irq) begin
         $display("Timeout: time_irq stayed high after mtimecmp was raised");
         stop_run();
      end

      if (uut.props.fail_count == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("Handshake assertions failed %0d times", uut.props.fail_count);
         stop_run();
      end
   end

endmodule

`default_nettype wire

//--- test/mmio_props.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_props (
   input wire logic            clk_in,
   input wire logic            rst_n,
   input wire logic            req,
   input wire mmio_pkg::word_t addr,
   input wire logic            rd,
   input wire logic            wr,
   input wire mmio_pkg::word_t wr_data,
   input wire mmio_pkg::size_t size,
   input wire logic            ack,
   input wire logic            dc_req,
   input wire logic            dc_ack,
   input wire logic            io_req,
   input wire logic            io_ack
);

   int fail_count = 0;                           // Failed assertions so far

   // CPU side holds its request until ack
   cpu_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
      req && !ack |=> req && $stable({addr, rd, wr, wr_data, size}))
      else begin
         fail_count++;
         $error("CPU request changed before ack");
      end

   ack_pulse: assert property (@(posedge clk_in) disable iff (!rst_n) ack |=> !ack)
      else begin
         fail_count++;
         $error("ack lasted two cycles");
      end

   // ------------------------------
   dc_hold: assert property (@(posedge clk_in) disable iff (!rst_n) dc_req && !dc_ack |=> dc_req)
      else begin
         fail_count++;
         $error("dc_req dropped before dc_ack");
      end

   io_hold: assert property (@(posedge clk_in) disable iff (!rst_n) io_req && !io_ack |=> io_req)
      else begin
         fail_count++;
         $error("io_req dropped before io_ack");
      end

   one_bus: assert property (@(posedge clk_in) disable iff (!rst_n) !(dc_req && io_req))
      else begin
         fail_count++;
         $error("dc_req and io_req high together");   // One transfer in flight
      end

endmodule

bind mmio_core mmio_props props (.clk_in, .rst_n, .req, .addr, .rd, .wr, .wr_data, .size,
   .ack, .dc_req, .dc_ack, .io_req, .io_ack);

`default_nettype wire

//--- rtl/mmio_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_macros.svh"

module mmio_core (
   input  wire logic            clk_in,
   input  wire logic            rst_n,
   // CPU memory stage
   input  wire logic            req,             // Held until ack
   input  wire mmio_pkg::word_t addr,
   input  wire logic            rd,
   input  wire logic            wr,
   input  wire mmio_pkg::word_t wr_data,
   input  wire mmio_pkg::size_t size,
   output logic                 ack,
   output logic                 ack_fault,
   output mmio_pkg::word_t      rd_data,
   // L1 data cache
   output logic                 dc_req,
   output mmio_pkg::word_t      dc_rw_addr,
   output logic                 dc_rd,
   output logic                 dc_wr,
   output mmio_pkg::word_t      dc_wr_data,
   output mmio_pkg::size_t      dc_size,
   input  wire logic            dc_ack,
   input  wire mmio_pkg::word_t dc_ack_data,
   // External I/O
   output logic                 io_req,
   output mmio_pkg::word_t      io_addr,
   output logic                 io_rd,
   output logic                 io_wr,
   output mmio_pkg::word_t      io_wr_data,
   input  wire logic            io_ack,
   input  wire logic            io_ack_fault,
   input  wire mmio_pkg::word_t io_rd_data,
   // Interrupts
   output logic                 time_irq,
   output logic                 sw_irq
);
   import mmio_pkg::*;

   mio_req_t                cpu_req;
   mio_rsp_t                cpu_rsp;
   dc_req_t                 dc_pl;
   io_req_t                 io_pl;
   logic                    mmr_wr;
   logic [`MMIO_OFS_W-1:0]  mmr_ofs;
   word_t                   mmr_wr_data;
   word_t                   mmr_rd_data;

   mio_link_if #(.payload_t(dc_req_t)) dc_link ();
   mio_link_if #(.payload_t(io_req_t)) io_link ();

   // ------------------------------
   assign cpu_req   = '{addr: addr, rd: rd, wr: wr, wr_data: wr_data, size: size};
   assign ack_fault = cpu_rsp.fault;
   assign rd_data   = cpu_rsp.rd_data;

   assign dc_rw_addr = dc_pl.rw_addr;
   assign dc_rd      = dc_pl.rd;
   assign dc_wr      = dc_pl.wr;
   assign dc_wr_data = dc_pl.wr_data;
   assign dc_size    = dc_pl.size;
   assign io_addr    = io_pl.addr;
   assign io_rd      = io_pl.rd;
   assign io_wr      = io_pl.wr;
   assign io_wr_data = io_pl.wr_data;

   mem_io_router MEM_IO (.clk_in, .rst_n, .cpu_req, .cpu_valid(req), .cpu_ack(ack), .cpu_rsp,
      .dc_link, .io_link, .mmr_wr, .mmr_ofs, .mmr_wr_data, .mmr_rd_data);

   // Cache never reports a fault
   bus_port #(.payload_t(dc_req_t)) DC_PORT (.clk_in, .rst_n, .link(dc_link), .ext_req(dc_req),
      .ext_payload(dc_pl), .ext_ack(dc_ack), .ext_rd_data(dc_ack_data), .ext_fault(1'b0));

   bus_port #(.payload_t(io_req_t)) IO_PORT (.clk_in, .rst_n, .link(io_link), .ext_req(io_req),
      .ext_payload(io_pl), .ext_ack(io_ack), .ext_rd_data(io_rd_data), .ext_fault(io_ack_fault));

   clint IRQ (.clk_in, .rst_n, .mmr_wr, .mmr_ofs, .mmr_wr_data, .mmr_rd_data,
      .time_irq, .sw_irq);                       // msip, mtimecmp and mtime live here

endmodule

`default_nettype wire

//--- rtl/clint.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_macros.svh"

module clint (
   input  wire logic                   clk_in,
   input  wire logic                   rst_n,
   input  wire logic                   mmr_wr,
   input  wire logic [`MMIO_OFS_W-1:0] mmr_ofs,     // Already checked by the router
   input  wire mmio_pkg::word_t        mmr_wr_data,
   output mmio_pkg::word_t             mmr_rd_data,
   output logic                        time_irq,
   output logic                        sw_irq
);

   logic [2*`MMIO_XLEN-1:0] mtime;
   logic [2*`MMIO_XLEN-1:0] mtime_nxt;
   logic [2*`MMIO_XLEN-1:0] mtimecmp;
   logic                    msip;
   logic                    wr_msip;
   logic                    wr_cmp_lo;
   logic                    wr_cmp_hi;
   logic                    wr_time_lo;
   logic                    wr_time_hi;

   // ------------------------------
   // Write decode
   assign wr_msip    = mmr_wr && (mmr_ofs == `MMIO_MSIP_OFS);
   assign wr_cmp_lo  = mmr_wr && (mmr_ofs == `MMIO_MTIMECMP_LO_OFS);
   assign wr_cmp_hi  = mmr_wr && (mmr_ofs == `MMIO_MTIMECMP_HI_OFS);
   assign wr_time_lo = mmr_wr && (mmr_ofs == `MMIO_MTIME_LO_OFS);
   assign wr_time_hi = mmr_wr && (mmr_ofs == `MMIO_MTIME_HI_OFS);

   // Free running count, software may overwrite either half
   always_comb begin
      mtime_nxt = mtime + 1'b1;
      if (wr_time_lo)
         mtime_nxt = {mtime[2*`MMIO_XLEN-1:`MMIO_XLEN], mmr_wr_data};
      if (wr_time_hi)
         mtime_nxt = {mmr_wr_data, mtime[`MMIO_XLEN-1:0]};
   end

   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         mtime    <= '0;
         mtimecmp <= `MMIO_MTIMECMP_RST;
         msip     <= 1'b0;
         time_irq <= 1'b0;
      end else begin
         mtime <= mtime_nxt;
         if (wr_cmp_lo)
            mtimecmp[`MMIO_XLEN-1:0] <= mmr_wr_data;
         if (wr_cmp_hi)
            mtimecmp[2*`MMIO_XLEN-1:`MMIO_XLEN] <= mmr_wr_data;
         if (wr_msip)
            msip <= mmr_wr_data[0];              // Only bit 0 is implemented
         time_irq <= (mtime >= mtimecmp);        // One cycle behind the compare
      end
   end

   assign sw_irq = msip;

   // ------------------------------
   // Read mux
   // mtime reads show next cycle's count, which is the count during the CPU ack
   always_comb begin
      case (mmr_ofs)
         `MMIO_MSIP_OFS:        mmr_rd_data = {{(`MMIO_XLEN-1){1'b0}}, msip};
         `MMIO_MTIMECMP_LO_OFS: mmr_rd_data = mtimecmp[`MMIO_XLEN-1:0];
         `MMIO_MTIMECMP_HI_OFS: mmr_rd_data = mtimecmp[2*`MMIO_XLEN-1:`MMIO_XLEN];
         `MMIO_MTIME_LO_OFS:    mmr_rd_data = mtime_nxt[`MMIO_XLEN-1:0];
         `MMIO_MTIME_HI_OFS:    mmr_rd_data = mtime_nxt[2*`MMIO_XLEN-1:`MMIO_XLEN];
         default:               mmr_rd_data = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/bus_port.sv
`timescale 1ns/1ps
`default_nettype none

module bus_port #(
   parameter type payload_t = mmio_pkg::io_req_t
) (
   input  wire logic            clk_in,
   input  wire logic            rst_n,
   mio_link_if.port             link,
   output logic                 ext_req,         // Held until ext_ack
   output payload_t             ext_payload,
   input  wire logic            ext_ack,
   input  wire mmio_pkg::word_t ext_rd_data,
   input  wire logic            ext_fault
);
   import mmio_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_RESP} state_t;

   state_t   state;
   mio_rsp_t rsp_q;                              // Reply taken on ext_ack

   // ------------------------------
   // Request side
   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         state       <= ST_IDLE;
         ext_payload <= '0;                      // rd/wr strobes low out of reset
      end else begin
         case (state)
            ST_IDLE: begin
               if (link.req) begin
                  ext_payload <= link.payload;   // Snapshot of the routed request
                  state       <= ST_WAIT;
               end
            end
            ST_WAIT: begin
               if (ext_ack)
                  state <= ST_RESP;
            end
            ST_RESP: state <= ST_IDLE;           // Link req drops during this cycle
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign ext_req = (state == ST_WAIT);

   // Response side
   always_ff @(posedge clk_in) begin
      if ((state == ST_WAIT) && ext_ack)
         rsp_q <= '{rd_data: ext_rd_data, fault: ext_fault};
   end

   assign link.ack = (state == ST_RESP);         // One cycle after ext_ack
   assign link.rsp = rsp_q;

endmodule

`default_nettype wire

//--- rtl/mem_io_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_macros.svh"

module mem_io_router (
   input  wire logic               clk_in,
   input  wire logic               rst_n,
   input  wire mmio_pkg::mio_req_t cpu_req,      // Held by the CPU until cpu_ack
   input  wire logic               cpu_valid,
   output logic                    cpu_ack,
   output mmio_pkg::mio_rsp_t      cpu_rsp,
   mio_link_if.router              dc_link,
   mio_link_if.router              io_link,
   output logic                    mmr_wr,       // CLINT register write strobe
   output logic [`MMIO_OFS_W-1:0]  mmr_ofs,
   output mmio_pkg::word_t         mmr_wr_data,
   input  wire mmio_pkg::word_t    mmr_rd_data
);
   import mmio_pkg::*;

   typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_ACK} state_t;

   state_t  state;
   target_t tgt;                                 // Decode of the live request
   target_t tgt_q;                               // Target latched for the transfer
   word_t   ofs;
   logic    in_clint;
   logic    in_ext_io;
   logic    ofs_ok;
   logic    start;
   logic    link_ack;

   // ------------------------------
   // Address decode
   assign ofs       = cpu_req.addr - `MMIO_CLINT_BASE;
   assign in_clint  = (cpu_req.addr >= `MMIO_CLINT_BASE) && (ofs < `MMIO_CLINT_SPAN);
   assign in_ext_io = (cpu_req.addr >= `MMIO_EXT_IO_LO) && (cpu_req.addr <= `MMIO_EXT_IO_HI);

   // Word aligned and one of the five defined registers
   assign ofs_ok = (ofs[`MMIO_XLEN-1:`MMIO_OFS_W] == '0) && (ofs[1:0] == 2'b00) &&
                   (ofs[`MMIO_OFS_W-1:0] inside {`MMIO_MSIP_OFS, `MMIO_MTIMECMP_LO_OFS,
                    `MMIO_MTIMECMP_HI_OFS, `MMIO_MTIME_LO_OFS, `MMIO_MTIME_HI_OFS});

   always_comb begin
      if (in_clint)
         tgt = ofs_ok ? CLINT : RESERVED;
      else if (in_ext_io)
         tgt = EXT_IO;
      else
         tgt = CACHE;                            // Everything else goes to L1 D$
   end

   assign start = (state == ST_IDLE) && cpu_valid;   // First cycle of a transfer

   // CLINT access completes here, write lands on this edge
   assign mmr_wr      = start && (tgt == CLINT) && cpu_req.wr;
   assign mmr_ofs     = ofs[`MMIO_OFS_W-1:0];
   assign mmr_wr_data = cpu_req.wr_data;

   // ------------------------------
   // Outbound links
   assign dc_link.req     = (state == ST_BUSY) && (tgt_q == CACHE);
   assign dc_link.payload = '{rw_addr: cpu_req.addr, rd: cpu_req.rd, wr: cpu_req.wr,
                              wr_data: cpu_req.wr_data, size: cpu_req.size};
   assign io_link.req     = (state == ST_BUSY) && (tgt_q == EXT_IO);
   assign io_link.payload = '{addr: cpu_req.addr, rd: cpu_req.rd, wr: cpu_req.wr,
                              wr_data: cpu_req.wr_data};

   assign link_ack = (tgt_q == CACHE) ? dc_link.ack : io_link.ack;

   always_ff @(posedge clk_in or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
         tgt_q <= CACHE;
      end else begin
         case (state)
            ST_IDLE: if (cpu_valid) begin
               tgt_q <= tgt;
               state <= ((tgt == CACHE) || (tgt == EXT_IO)) ? ST_BUSY : ST_ACK;
            end
            ST_BUSY: if (link_ack) state <= ST_ACK;   // Wait out the bus port
            ST_ACK:  state <= ST_IDLE;                // Req still high here, ignore it
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Registered response toward the CPU
   always_ff @(posedge clk_in) begin
      if (start && (tgt == CLINT))
         cpu_rsp <= '{rd_data: mmr_rd_data, fault: 1'b0};
      else if (start && (tgt == RESERVED))
         cpu_rsp <= '{rd_data: '0, fault: 1'b1};      // No side effects
      else if ((state == ST_BUSY) && link_ack)
         cpu_rsp <= (tgt_q == CACHE) ? dc_link.rsp : io_link.rsp;
   end

   assign cpu_ack = (state == ST_ACK);

endmodule

`default_nettype wire

//--- rtl/mio_link_if.sv
`timescale 1ns/1ps
`default_nettype none

// One routed req/ack link between the router and a bus port
interface mio_link_if #(
   parameter type payload_t = mmio_pkg::io_req_t
) ();
   import mmio_pkg::*;

   logic     req;                               // Held until ack
   payload_t payload;                           // Stable while req is high
   logic     ack;                               // Single cycle pulse
   mio_rsp_t rsp;                               // Valid with ack

   // ------------------------------
   modport router (
      output req, payload,
      input  ack, rsp
   );

   modport port (
      input  req, payload,
      output ack, rsp
   );

endinterface

`default_nettype wire

//--- rtl/mmio_pkg.sv
`default_nettype none

`include "mmio_macros.svh"

package mmio_pkg;

   typedef logic [`MMIO_XLEN-1:0]   word_t;
   typedef logic [`MMIO_SIZE_W-1:0] size_t;     // Bytes: 1, 2 or 4

   // Load or store from the memory stage
   typedef struct packed {
      word_t addr;
      logic  rd;
      logic  wr;
      word_t wr_data;
      size_t size;
   } mio_req_t;

   // L1 data cache request
   typedef struct packed {
      word_t rw_addr;
      logic  rd;
      logic  wr;
      word_t wr_data;
      size_t size;
   } dc_req_t;

   typedef struct packed {
      word_t addr;
      logic  rd;
      logic  wr;
      word_t wr_data;
   } io_req_t;                                  // External I/O, word wide only

   typedef struct packed {
      word_t rd_data;
      logic  fault;
   } mio_rsp_t;

   typedef enum logic [1:0] {CACHE, EXT_IO, CLINT, RESERVED} target_t;

endpackage

`default_nettype wire

//--- rtl/mmio_macros.svh
`ifndef MMIO_MACROS_SVH
`define MMIO_MACROS_SVH

// Data path and access size widths
`define MMIO_XLEN            32
`define MMIO_SIZE_W          3
`define MMIO_OFS_W           5                        // Enough to reach the top CLINT register

// External I/O window
`define MMIO_EXT_IO_LO       32'hF000_0000
`define MMIO_EXT_IO_HI       32'hFFFE_FFFF

// Internal timer and interrupt window
`define MMIO_CLINT_BASE      32'hFFFF_0000
`define MMIO_CLINT_SPAN      32'h0001_0000            // 64 KiB
`define MMIO_MSIP_OFS        5'd0
`define MMIO_MTIMECMP_LO_OFS 5'd8
`define MMIO_MTIMECMP_HI_OFS 5'd12
`define MMIO_MTIME_LO_OFS    5'd16
`define MMIO_MTIME_HI_OFS    5'd20

`define MMIO_MTIMECMP_RST    64'hFFFF_FFFF_FFFF_FFFF  // Never reached, no timer irq after reset

`endif
